//--- filelist.f
+incdir+.
sprite_pkg.sv
sprite_bus_if.sv
video_timing.sv
sprite_locate.sv
image_memory.sv
pixel_mixer.sv
sprite_display.sv
tb_clock.sv
sprite_checker.sv
tb_sprite_display.sv

//--- Makefile
# Verilator build and run for the sprite display testbench.

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module tb_sprite_display -f filelist.f

sim:
	verilator --binary --timing --top-module tb_sprite_display -f filelist.f \
		--Mdir $(OBJ_DIR) -o sim_bin
	./$(OBJ_DIR)/sim_bin | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_sprite_display.sv
`timescale 1ns/1ps

`include "sprite_config.svh"

module tb_sprite_display;
  import sprite_pkg::*;

  localparam int mem_words   = `MEM_WIDTH * `MEM_HEIGHT;
  localparam int ack_limit   = 20;  // Cycles per handshake phase.
  localparam int frame_limit = 4 * `H_TOTAL * `V_TOTAL;

  logic                  clk;
  logic                  reset;
  logic                  write_req;
  logic [`ADDR_BITS-1:0] write_addr;
  pixel_t                write_data;
  logic                  write_ack;
  logic                  pix_valid;
  logic [9:0]            pix_x;
  logic [9:0]            pix_y;
  pixel_t                pixel;

  pixel_t      shadow [mem_words];
  logic        shadow_valid;
  int          timeout_count;
  logic [31:0] rng_state;

  tb_clock clock_gen (.clk(clk), .reset(reset));

  sprite_display sprite_display_i (
    .clk        (clk),
    .reset      (reset),
    .write_req  (write_req),
    .write_addr (write_addr),
    .write_data (write_data),
    .write_ack  (write_ack),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pixel      (pixel)
  );

  sprite_checker sprite_checker_i (
    .clk       (clk),
    .reset     (reset),
    .write_req (write_req),
    .write_ack (write_ack),
    .pix_valid (pix_valid),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pixel     (pixel)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Starts and ends on a falling edge.
  task automatic write_word(input logic [`ADDR_BITS-1:0] addr, input pixel_t data,
                            output bit ok);
    int waited;
    ok         = 1'b1;
    write_addr = addr;
    write_data = data;
    write_req  = 1'b1;
    waited     = 0;
    while (write_ack !== 1'b1 && waited < ack_limit) begin
      @(negedge clk);
      waited++;
    end
    if (write_ack !== 1'b1) begin
      $display("Timeout: write_ack never rose for address %0d", addr);
      timeout_count++;
      ok = 1'b0;
    end
    write_req = 1'b0;
    waited    = 0;
    while (write_ack !== 1'b0 && waited < ack_limit) begin
      @(negedge clk);
      waited++;
    end
    if (write_ack !== 1'b0) begin
      $display("Timeout: write_ack stayed high after write_req fell, address %0d", addr);
      timeout_count++;
      ok = 1'b0;
    end
  endtask

  task automatic load_memory(output bit ok);
    pixel_t data;
    bit     word_ok;
    ok = 1'b1;
    for (int i = 0; i < mem_words && ok; i++) begin
      rng_state = xorshift(rng_state);
      data = (rng_state[31:30] == 2'b00) ? '0 : rng_state;  // About one in four transparent.
      write_word(`ADDR_BITS'(i), data, word_ok);
      shadow[`ADDR_BITS'(i)] = data;
      ok = word_ok;
    end
  endtask

  task automatic wait_for_reset(output bit ok);
    int waited;
    waited = 0;
    while (reset !== 1'b0 && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    ok = (reset === 1'b0);
    if (!ok) begin
      $display("Timeout: reset was never released");
      timeout_count++;
    end
  endtask

  task automatic wait_for_frames(input int frames, output bit ok);
    int waited;
    waited = 0;
    while (sprite_checker_i.frames_checked < frames && waited < frame_limit) begin
      @(negedge clk);
      waited++;
    end
    ok = (sprite_checker_i.frames_checked >= frames);
    if (!ok) begin
      $display("Timeout: only %0d of %0d frames were checked",
               sprite_checker_i.frames_checked, frames);
      timeout_count++;
    end
  endtask

  task automatic report_result();
    int errors;
    errors = sprite_checker_i.mismatch_count + sprite_checker_i.other_count + timeout_count;
    $display("Errors: %0d (%0d mismatches, %0d other, %0d timeouts), %0d pixels checked",
             errors, sprite_checker_i.mismatch_count, sprite_checker_i.other_count,
             timeout_count, sprite_checker_i.pixels_checked);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    write_req     = 1'b0;
    write_addr    = '0;
    write_data    = '0;
    shadow_valid  = 1'b0;
    timeout_count = 0;
    rng_state     = 32'd22292;
    wait_for_reset(ok);
    if (ok) begin
      @(negedge clk);
      load_memory(ok);
    end
    if (ok) begin
      shadow_valid = 1'b1;
      wait_for_frames(2, ok);
    end
    report_result();
  end

endmodule

//--- sprite_checker.sv
`timescale 1ns/1ps

`include "sprite_config.svh"

module sprite_checker (
  input logic               clk,
  input logic               reset,
  input logic               write_req,
  input logic               write_ack,
  input logic               pix_valid,
  input logic [9:0]         pix_x,
  input logic [9:0]         pix_y,
  input sprite_pkg::pixel_t pixel
);
  import sprite_pkg::*;

  int mismatch_count = 0;
  int other_count    = 0;
  int pixels_checked = 0;
  int frames_checked = 0;
  int since_release  = 0;  // Rising edges seen since reset went low.
  int visible        = 0;
  int exp_x          = 0;
  int exp_y          = 0;
  bit locked         = 1'b0;
  bit checking       = 1'b0;
  bit reset_d        = 1'b0;
  bit req_d          = 1'b0;
  bit ack_d          = 1'b0;

  // Image word under (x, y), or -1 outside all windows.
  function automatic int window_addr(input int x, input int y);
    int col;
    int top;
    if (x < `SPRITE_X0 || x >= `SPRITE_X3 + `SPRITE_SIZE) return -1;
    col = (x - `SPRITE_X0) / `SPRITE_SIZE;
    if (y >= `SPRITE_Y0 && y < `SPRITE_Y0 + `SPRITE_SIZE) begin
      top = `SPRITE_Y0;
    end else if (y >= `SPRITE_Y1 && y < `SPRITE_Y1 + `SPRITE_SIZE) begin
      top = `SPRITE_Y1;  // Bottom windows read the same strip.
    end else begin
      return -1;
    end
    return (y - top) * `MEM_WIDTH + col * `SPRITE_SIZE + (x - `SPRITE_X0) % `SPRITE_SIZE;
  endfunction

  function automatic pixel_t expected_pixel(input int x, input int y);
    int     addr;
    pixel_t bg;
    if (x >= `H_ACTIVE || y >= `V_ACTIVE) return '0;
    bg = ((((x ^ y) >> `TILE_SHIFT) & 1) != 0) ? `BG_DARK : `BG_LIGHT;
    addr = window_addr(x, y);
    if (addr < 0 || tb_sprite_display.shadow[`ADDR_BITS'(addr)] == '0) return bg;
    return tb_sprite_display.shadow[`ADDR_BITS'(addr)];
  endfunction

  always @(posedge clk) begin
    int     x;
    int     y;
    bit     want_valid;
    pixel_t want;
    x = int'(pix_x);
    y = int'(pix_y);
    if (reset_d && (pix_valid !== 1'b0 || write_ack !== 1'b0)) begin
      $display("Error at %0d ns: pix_valid or write_ack is not low during reset", $time);
      other_count++;
    end
    if (!reset_d && !ack_d && write_ack === 1'b1 && !req_d) begin
      $display("Error at %0d ns: write_ack rose without a write request", $time);
      other_count++;
    end
    if (ack_d && write_ack === 1'b0 && req_d) begin
      $display("Error at %0d ns: write_ack fell while write_req was still high", $time);
      other_count++;
    end
    if (!locked && reset === 1'b0 && pix_valid === 1'b1) begin
      if (since_release < 3) begin
        $display("Error at %0d ns: pix_valid rose before the pipeline filled", $time);
        other_count++;
      end
      locked = 1'b1;  // First visible pixel is (0, 0).
    end
    if (locked) begin
      if (x != exp_x || y != exp_y) begin
        $display("Mismatch at %0d ns: pix_x,pix_y expected %0d,%0d got %0d,%0d",
                 $time, exp_x, exp_y, x, y);
        mismatch_count++;
      end
      want_valid = (x < `H_ACTIVE && y < `V_ACTIVE);
      if (pix_valid !== want_valid) begin
        $display("Mismatch at %0d ns: pix_valid at (%0d,%0d) expected %0b got %0b",
                 $time, x, y, want_valid, pix_valid);
        mismatch_count++;
      end
      if (want_valid) visible++;
      if (checking) begin
        want = expected_pixel(x, y);  // Blank pixels must read as zero.
        pixels_checked++;
        if (pixel !== want) begin
          $display("Mismatch at %0d ns: pixel at (%0d,%0d) expected %08h got %08h",
                   $time, x, y, want, pixel);
          mismatch_count++;
        end
      end
      if (x == `H_TOTAL - 1 && y == `V_TOTAL - 1) begin
        if (visible != `H_ACTIVE * `V_ACTIVE) begin
          $display("Error at %0d ns: a frame showed %0d visible pixels instead of %0d",
                   $time, visible, `H_ACTIVE * `V_ACTIVE);
          other_count++;
        end
        if (checking) frames_checked++;
        visible  = 0;
        checking = tb_sprite_display.shadow_valid;  // Compare whole frames only.
      end
      exp_x = (x + 1) % `H_TOTAL;
      exp_y = (exp_x == 0) ? (y + 1) % `V_TOTAL : y;
    end
    since_release = (reset === 1'b0) ? since_release + 1 : 0;
    reset_d = reset;
    req_d   = write_req;
    ack_d   = write_ack;
  end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  // Held over four rising edges, released on a falling edge.
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- sprite_display.sv
`timescale 1ns/1ps

`include "sprite_config.svh"

module sprite_display (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  write_req,
  input  logic [`ADDR_BITS-1:0] write_addr,
  input  sprite_pkg::pixel_t    write_data,
  output logic                  write_ack,
  output logic                  pix_valid,
  output logic [9:0]            pix_x,
  output logic [9:0]            pix_y,
  output sprite_pkg::pixel_t    pixel
);

  logic               [9:0] pos_x;
  logic               [9:0] pos_y;
  logic                     active;
  sprite_pkg::pixel_t       mem_pixel;

  sprite_bus_if loc_bus ();
  sprite_bus_if mem_bus ();

  video_timing video_timing_i (
    .clk    (clk),
    .reset  (reset),
    .pos_x  (pos_x),
    .pos_y  (pos_y),
    .active (active)
  );

  sprite_locate sprite_locate_i (
    .clk    (clk),
    .reset  (reset),
    .pos_x  (pos_x),
    .pos_y  (pos_y),
    .active (active),
    .loc    (loc_bus.src)
  );

  image_memory image_memory_i (
    .clk        (clk),
    .reset      (reset),
    .loc        (loc_bus.dst),
    .out        (mem_bus.src),
    .pixel      (mem_pixel),
    .write_req  (write_req),
    .write_addr (write_addr),
    .write_data (write_data),
    .write_ack  (write_ack)
  );

  pixel_mixer pixel_mixer_i (
    .clk       (clk),
    .reset     (reset),
    .mem       (mem_bus.dst),
    .pixel     (mem_pixel),
    .pix_valid (pix_valid),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_out   (pixel)
  );

endmodule

//--- pixel_mixer.sv
`timescale 1ns/1ps

`include "sprite_config.svh"

module pixel_mixer (
  input  logic               clk,
  input  logic               reset,
  sprite_bus_if.dst          mem,
  input  sprite_pkg::pixel_t pixel,
  output logic               pix_valid,
  output logic [9:0]         pix_x,
  output logic [9:0]         pix_y,
  output sprite_pkg::pixel_t pix_out
);
  import sprite_pkg::*;

  logic   tile_bit;
  pixel_t bg_color;
  pixel_t pix_d;

  // Checkerboard of 16 by 16 tiles.
  assign tile_bit = mem.pix_x[`TILE_SHIFT] ^ mem.pix_y[`TILE_SHIFT];
  assign bg_color = tile_bit ? `BG_DARK : `BG_LIGHT;

  always_comb begin
    case (mem.region)
      region_sprite: pix_d = (pixel != '0) ? pixel : bg_color;  // Zero is transparent.
      region_bg:     pix_d = bg_color;
      default:       pix_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= mem.valid;
    end
  end

  always_ff @(posedge clk) begin
    pix_x   <= mem.pix_x;
    pix_y   <= mem.pix_y;
    pix_out <= pix_d;
  end

endmodule

//--- image_memory.sv
`timescale 1ns/1ps

`include "sprite_config.svh"

module image_memory (
  input  logic                  clk,
  input  logic                  reset,
  sprite_bus_if.dst             loc,
  sprite_bus_if.src             out,
  output sprite_pkg::pixel_t    pixel,
  input  logic                  write_req,
  input  logic [`ADDR_BITS-1:0] write_addr,
  input  sprite_pkg::pixel_t    write_data,
  output logic                  write_ack
);
  import sprite_pkg::*;

  localparam int depth = `MEM_WIDTH * `MEM_HEIGHT;

  pixel_t                mem [depth];
  logic [`ADDR_BITS-1:0] rd_addr;
  wr_state_t             state;
  wr_state_t             state_next;

  // Bottom sprites reuse the top strip, so only the column bits matter.
  assign rd_addr = `ADDR_BITS'(loc.off_y) * `ADDR_BITS'(`MEM_WIDTH)
                 + `ADDR_BITS'(loc.sprite[1:0]) * `ADDR_BITS'(`SPRITE_SIZE)
                 + `ADDR_BITS'(loc.off_x);

  always_ff @(posedge clk) begin
    pixel <= mem[rd_addr];
    if (state == wr_write && write_addr < `ADDR_BITS'(depth)) begin
      mem[write_addr] <= write_data;  // Separate port, video reads never wait.
    end
  end

  // Lookup travels alongside the read data.
  always_ff @(posedge clk) begin
    if (reset) begin
      out.valid  <= 1'b0;
      out.region <= region_blank;
    end else begin
      out.valid  <= loc.valid;
      out.region <= loc.region;
    end
  end

  always_ff @(posedge clk) begin
    out.sprite <= loc.sprite;
    out.off_x  <= loc.off_x;
    out.off_y  <= loc.off_y;
    out.pix_x  <= loc.pix_x;
    out.pix_y  <= loc.pix_y;
  end

  always_comb begin
    state_next = state;
    case (state)
      wr_idle:  if (write_req) state_next = wr_write;
      wr_write: state_next = wr_hold;
      wr_hold:  if (!write_req) state_next = wr_idle;  // Wait for host to drop req.
      default:  state_next = wr_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wr_idle;
    end else begin
      state <= state_next;
    end
  end

  assign write_ack = (state == wr_hold);

endmodule

//--- sprite_locate.sv
`timescale 1ns/1ps

`include "sprite_config.svh"

module sprite_locate (
  input  logic       clk,
  input  logic       reset,
  input  logic [9:0] pos_x,
  input  logic [9:0] pos_y,
  input  logic       active,
  sprite_bus_if.src  loc
);
  import sprite_pkg::*;

  localparam logic [9:0] col_x [4] = '{10'(`SPRITE_X0), 10'(`SPRITE_X1),
                                       10'(`SPRITE_X2), 10'(`SPRITE_X3)};
  localparam logic [9:0] row_y [2] = '{10'(`SPRITE_Y0), 10'(`SPRITE_Y1)};
  localparam logic [9:0] size = 10'(`SPRITE_SIZE);

  logic       col_hit;
  logic       row_hit;
  logic [1:0] col_idx;
  logic       row_idx;
  logic [9:0] rel_x;
  logic [9:0] rel_y;
  region_t    region_d;

  // Windows never overlap, so at most one column and one row match.
  always_comb begin
    col_hit = 1'b0;
    col_idx = 2'd0;
    rel_x   = '0;
    for (int i = 0; i < 4; i++) begin
      if (pos_x >= col_x[i] && pos_x < col_x[i] + size) begin
        col_hit = 1'b1;
        col_idx = 2'(i);
        rel_x   = pos_x - col_x[i];
      end
    end

    row_hit = 1'b0;
    row_idx = 1'b0;
    rel_y   = '0;
    for (int j = 0; j < 2; j++) begin
      if (pos_y >= row_y[j] && pos_y < row_y[j] + size) begin
        row_hit = 1'b1;
        row_idx = 1'(j);
        rel_y   = pos_y - row_y[j];
      end
    end

    if (!active) begin
      region_d = region_blank;
    end else if (col_hit && row_hit) begin
      region_d = region_sprite;
    end else begin
      region_d = region_bg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      loc.valid  <= 1'b0;
      loc.region <= region_blank;
    end else begin
      loc.valid  <= active;
      loc.region <= region_d;
    end
  end

  always_ff @(posedge clk) begin
    loc.sprite <= {row_idx, col_idx};  // Bottom row sets bit 2.
    loc.off_x  <= rel_x[6:0];
    loc.off_y  <= rel_y[6:0];
    loc.pix_x  <= pos_x;
    loc.pix_y  <= pos_y;
  end

endmodule

//--- video_timing.sv
`timescale 1ns/1ps

`include "sprite_config.svh"

module video_timing (
  input  logic       clk,
  input  logic       reset,
  output logic [9:0] pos_x,
  output logic [9:0] pos_y,
  output logic       active
);

  logic x_wrap;
  logic y_wrap;

  assign x_wrap = (pos_x == 10'(`H_TOTAL - 1));
  assign y_wrap = (pos_y == 10'(`V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      pos_x <= '0;
    end else if (x_wrap) begin
      pos_x <= '0;
    end else begin
      pos_x <= pos_x + 10'd1;
    end
  end

  // Vertical counter steps once per line.
  always_ff @(posedge clk) begin
    if (reset) begin
      pos_y <= '0;
    end else if (x_wrap) begin
      if (y_wrap) begin
        pos_y <= '0;
      end else begin
        pos_y <= pos_y + 10'd1;
      end
    end
  end

  assign active = (pos_x < 10'(`H_ACTIVE)) && (pos_y < 10'(`V_ACTIVE));

endmodule

//--- sprite_bus_if.sv
`timescale 1ns/1ps

interface sprite_bus_if;
  import sprite_pkg::*;

  logic       valid;   // Pixel is in the active area.
  region_t    region;
  logic [2:0] sprite;  // Row bit and column index.
  logic [6:0] off_x;
  logic [6:0] off_y;
  logic [9:0] pix_x;
  logic [9:0] pix_y;

  modport src (
    output valid, region, sprite, off_x, off_y, pix_x, pix_y
  );

  modport dst (
    input valid, region, sprite, off_x, off_y, pix_x, pix_y
  );

endinterface

//--- sprite_pkg.sv
package sprite_pkg;

  // One 32-bit pixel word.
  typedef logic [31:0] pixel_t;

  // Four-phase write handshake states.
  typedef enum logic [1:0] {
    wr_idle  = 2'd0,
    wr_write = 2'd1,
    wr_hold  = 2'd2
  } wr_state_t;

  // What covers the current pixel.
  typedef enum logic [1:0] {
    region_bg     = 2'd0,  // Active area, outside all windows.
    region_sprite = 2'd1,  // Inside one of the eight windows.
    region_blank  = 2'd2   // Outside the active area.
  } region_t;

endpackage

//--- sprite_config.svh
`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

`define H_ACTIVE    800
`define H_TOTAL     840
`define V_ACTIVE    720
`define V_TOTAL     730

`define SPRITE_SIZE 100
`define SPRITE_X0   100
`define SPRITE_X1   200
`define SPRITE_X2   300
`define SPRITE_X3   400
`define SPRITE_Y0   10
`define SPRITE_Y1   600

`define MEM_WIDTH   800
`define MEM_HEIGHT  100
`define ADDR_BITS   17

`define BG_LIGHT    32'h00c8c8c8
`define BG_DARK     32'h00404040
`define TILE_SHIFT  4

`endif
